/* test/pulse_gen_testdata.txt */
// mode period p1_width delay p2_width cpmg block block_off exp_period exp_edges exp_inhibit
// mode 0 reset values, 1 full set, 2 stray byte then full set, 3 period only
// hahn echo defaults after reset
0 1000 1e c8 3c 1 1 64 1000 2 186
// cpmg train of four
1 bb8 14 32 28 4 1 50 bb8 5 262
// period change only
3 a28 14 32 28 4 1 50 a28 5 262
// blanking off
1 bb8 19 28 32 2 0 3c bb8 3 0
// excitation only
1 c80 64 50 1e 0 1 32 c80 1 96
// stray byte ahead of the frames
2 fa0 c 1e 18 3 1 28 fa0 4 112
// sequence cut at the period end
1 258 28 64 50 3 1 c8 258 3 258

/* pulse_gen.f */
+incdir+verilog
verilog/pulse_pkg.sv
verilog/uart_rx.sv
verilog/param_loader.sv
verilog/pulse_sequencer.sv
verilog/pulse_gen.sv
test/pulse_gen_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench, pass only if the pass message shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f pulse_gen.f --top-module pulse_gen_tb -o sim_pulse_gen \
	&& ./obj_dir/sim_pulse_gen | tee /dev/stderr \
	| grep -q "Simulation completed successfully" \
	&& echo "run_sim: PASS" \
	|| { echo "run_sim: FAIL"; exit 1; }

/* test/pulse_gen_tb.sv */
`timescale 1ns/1ps
`include "pulse_gen_config.svh"

module pulse_gen_tb import pulse_pkg::*; ();

	localparam int NROWS = 7;
	localparam int NCOLS = 11;
	localparam int CPB = `UART_CLKS_PER_BIT;

	bit clk;
	logic resetn;
	logic rs232_rx;
	pulse_outs_t outs;

	// rows back to back with one word per column
	logic [31:0] tdata [0:NROWS*NCOLS-1];
	integer seed;
	// model set in force and the one waiting for the next period
	pulse_params_t cur;
	pulse_params_t next_set;
	int t_model;
	int sets_sent;
	int sets_applied;
	// totals of the last complete period
	int sync_rises, cyc, edges, inhib;
	int last_interval, last_edges, last_inhibit;
	logic prev_sync, prev_pulse;
	int out_errors, count_errors, timeouts;
	logic timed_out;

	pulse_gen pulse_gen_i (
		.clk(clk),
		.resetn(resetn),
		.rs232_rx(rs232_rx),
		.outs(outs)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic pulse_params_t row_params(input int r);
		pulse_params_t p;
		int b;
		b = r * NCOLS;
		p.period = tdata[b+1][23:0];
		p.p1_width = tdata[b+2][15:0];
		p.delay = tdata[b+3][15:0];
		p.p2_width = tdata[b+4][15:0];
		p.cpmg = tdata[b+5][7:0];
		p.block = tdata[b+6][0];
		p.block_off = tdata[b+7][15:0];
		return p;
	endfunction

	// outputs at cycle t of a period from the timing rule
	function automatic pulse_outs_t expected_outs(input pulse_params_t p, input int t);
		pulse_outs_t o;
		int p1, d, p2, st, last_end;
		p1 = int'(p.p1_width);
		d = int'(p.delay);
		p2 = int'(p.p2_width);
		o = '0;
		if (t >= 0) begin
			o.sync = (t < `SYNC_WIDTH);
			o.pulse = (t < p1);
			// refocusing pulse k starts one delay plus k-1 echo spacings later
			for (int k = 1; k <= int'(p.cpmg); k++) begin
				st = p1 + d + (k - 1) * (p2 + 2 * d);
				if (t >= st && t < st + p2)
					o.pulse = 1'b1;
			end
			last_end = (p.cpmg == 8'd0) ? p1 : p1 + int'(p.cpmg) * (p2 + 2 * d) - d;
			o.inhibit = p.block && (t < last_end + int'(p.block_off));
		end
		return o;
	endfunction

	task automatic check_outs(input pulse_outs_t got, input pulse_outs_t exp, input int t);
		if (got !== exp) begin
			$display("[FAIL] %0t: outs at t=%0d are %b, expected %b", $time, t, got, exp);
			out_errors++;
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, exp);
			count_errors++;
		end
	endtask

	// 8N1 lsb first with random idle bit times after each byte
	task automatic send_byte(input logic [7:0] b);
		int idle;
		rs232_rx = 1'b0;
		repeat (CPB) @(negedge clk);
		for (int i = 0; i < 8; i++) begin
			rs232_rx = b[i];
			repeat (CPB) @(negedge clk);
		end
		rs232_rx = 1'b1;
		repeat (CPB) @(negedge clk);
		idle = $unsigned($random(seed)) % 4;
		repeat (idle * CPB) @(negedge clk);
	endtask

	task automatic send_cmd(input cmd_op_t op, input logic [23:0] val, input int n);
		send_byte(op);
		for (int i = n - 1; i >= 0; i--)
			send_byte(val[8*i +: 8]);
	endtask

	task automatic send_full(input pulse_params_t p);
		send_cmd(OP_SET_PERIOD, p.period, 3);
		send_cmd(OP_SET_P1, 24'(p.p1_width), 2);
		send_cmd(OP_SET_DELAY, 24'(p.delay), 2);
		send_cmd(OP_SET_P2, 24'(p.p2_width), 2);
		send_cmd(OP_SET_CPMG, 24'(p.cpmg), 1);
		send_cmd(OP_SET_BLOCK, 24'(p.block), 1);
		send_cmd(OP_SET_BLOCK_OFF, 24'(p.block_off), 2);
	endtask

	task automatic wait_sync(input int per);
		int n0;
		int cnt;
		n0 = sync_rises;
		cnt = 0;
		while (sync_rises == n0 && cnt < 2 * per + 100) begin
			@(negedge clk);
			cnt++;
		end
		if (sync_rises == n0) begin
			$display("timeout: no sync edge arrived within %0d cycles", 2 * per + 100);
			timeouts++;
			timed_out = 1'b1;
		end
	endtask

	// mode 0 keeps the reset set
	// mode 2 leads with a stray byte
	// mode 3 sends the period only
	task automatic run_row(input int r);
		pulse_params_t p;
		pulse_params_t old;
		int mode;
		p = row_params(r);
		old = cur;
		mode = int'(tdata[r*NCOLS]);
		if (mode != 0) begin
			if (mode == 2)
				send_byte(8'h5a);
			if (mode == 3)
				send_cmd(OP_SET_PERIOD, p.period, 3);
			else
				send_full(p);
			// one more bit time for the last frame to land
			repeat (CPB) @(negedge clk);
			next_set = p;
			sets_sent++;
		end
		wait_sync(int'(old.period));
		if (timed_out)
			return;
		if (mode != 0)
			check_count(last_interval, int'(old.period), "sync interval while loading");
		wait_sync(int'(p.period));
		if (timed_out)
			return;
		check_count(last_interval, int'(tdata[r*NCOLS+8]), "sync interval");
		check_count(last_edges, int'(tdata[r*NCOLS+9]), "pulse edges");
		check_count(last_inhibit, int'(tdata[r*NCOLS+10]), "inhibit cycles");
	endtask

	// pre-edge outs close the cycle just ended before the model steps
	always @(posedge clk) begin
		if (outs.sync && !prev_sync) begin
			sync_rises++;
			last_interval = cyc;
			last_edges = edges;
			last_inhibit = inhib;
			cyc = 0;
			edges = 0;
			inhib = 0;
		end
		cyc++;
		if (outs.pulse && !prev_pulse)
			edges++;
		if (outs.inhibit)
			inhib++;
		prev_sync = outs.sync;
		prev_pulse = outs.pulse;
		if (resetn) begin
			t_model = -1;
			cur = row_params(0);
		end else if (t_model == -1 || t_model == int'(cur.period) - 1) begin
			t_model = 0;
			// new set takes over at the period boundary
			if (sets_applied != sets_sent) begin
				cur = next_set;
				sets_applied = sets_sent;
			end
		end else if (t_model >= 0) begin
			t_model++;
		end
	end

	always @(negedge clk) begin
		if (t_model >= -1)
			check_outs(outs, expected_outs(cur, t_model), t_model);
	end

	initial begin
		$timeformat(-9, 0, " ns", 0);
		seed = 10842;
		resetn = 1'b1;
		rs232_rx = 1'b1;
		t_model = -2;
		sets_sent = 0;
		sets_applied = 0;
		sync_rises = 0;
		cyc = 0;
		edges = 0;
		inhib = 0;
		last_interval = 0;
		last_edges = 0;
		last_inhibit = 0;
		prev_sync = 1'b0;
		prev_pulse = 1'b0;
		out_errors = 0;
		count_errors = 0;
		timeouts = 0;
		timed_out = 1'b0;
		next_set = '0;
		$readmemh("test/pulse_gen_testdata.txt", tdata);
		repeat (8) @(negedge clk);
		resetn = 1'b0;
		for (int r = 0; r < NROWS; r++) begin
			if (!timed_out)
				run_row(r);
		end
		$display("errors: %0d output, %0d count, %0d timeout", out_errors, count_errors,
			timeouts);
		if (out_errors == 0 && count_errors == 0 && timeouts == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* verilog/pulse_gen.sv */
`timescale 1ns/1ps

module pulse_gen import pulse_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic rs232_rx,
	output pulse_outs_t outs
);

	// received byte stream
	logic [7:0] rx_byte;
	logic rx_valid;
	// current parameter set
	pulse_params_t params;

	uart_rx uart_rx_i (
		.clk(clk),
		.resetn(resetn),
		.rx(rs232_rx),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid)
	);

	// command decode and parameter store
	param_loader param_loader_i (
		.clk(clk),
		.resetn(resetn),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid),
		.params(params)
	);

	pulse_sequencer pulse_sequencer_i (
		.clk(clk),
		.resetn(resetn),
		.params(params),
		.outs(outs)
	);

endmodule

/* verilog/pulse_sequencer.sv */
`timescale 1ns/1ps
`include "pulse_gen_config.svh"

module pulse_sequencer import pulse_pkg::*; (
	input logic clk,
	input logic resetn,
	input pulse_params_t params,
	output pulse_outs_t outs
);

	// room for the doubled delay
	localparam int SEG_W = `PULSE_TIME_W + 1;
	localparam int SYNC_W = $clog2(`SYNC_WIDTH + 1);

	// shadow params, fixed for one period
	pulse_params_t sh;
	pulse_params_t sh_n;
	// down counter, zero marks the last cycle of the period
	logic [`PULSE_PERIOD_W-1:0] per_cnt;
	logic [`PULSE_PERIOD_W-1:0] per_n;
	logic [SYNC_W-1:0] sync_cnt;
	logic [SYNC_W-1:0] sync_n;
	seq_state_t state;
	seq_state_t state_n;
	// cycles left in the segment, current one included
	logic [SEG_W-1:0] seg_cnt;
	logic [SEG_W-1:0] seg_n;
	// refocusing pulses not yet started
	logic [7:0] left;
	logic [7:0] left_n;
	logic start;

	// segment that follows s
	function automatic seq_state_t succ(input seq_state_t s, input logic [7:0] l,
			input pulse_params_t p);
		case (s)
			// empty train when both gap and pulse are zero
			SEQ_P1: return (l != 8'd0 && (p.delay != '0 || p.p2_width != '0)) ?
					SEQ_GAP : SEQ_TAIL;
			SEQ_GAP: return SEQ_P2;
			SEQ_P2: return (l != 8'd0) ? SEQ_GAP : SEQ_TAIL;
			default: return SEQ_WAIT;
		endcase
	endfunction

	// enter segment s, skipping zero length ones
	function automatic void enter(input seq_state_t s_in, input logic [7:0] l_in,
			input pulse_params_t p, output seq_state_t st, output logic [SEG_W-1:0] cnt,
			output logic [7:0] lft);
		seq_state_t s;
		logic [7:0] l;
		logic [SEG_W-1:0] len;
		logic found;
		s = s_in;
		l = l_in;
		found = 1'b0;
		st = SEQ_WAIT;
		cnt = '0;
		lft = l_in;
		// at most five segments in a row
		for (int i = 0; i < 5; i++) begin
			if (!found) begin
				case (s)
					SEQ_P1: len = SEG_W'(p.p1_width);
					// first gap is one delay, later ones two
					SEQ_GAP: len = (l == p.cpmg) ? SEG_W'(p.delay) : {p.delay, 1'b0};
					SEQ_P2: begin
						l = l - 1'b1;
						len = SEG_W'(p.p2_width);
					end
					SEQ_TAIL: len = SEG_W'(p.block_off);
					default: len = '0;
				endcase
				if (len != '0 || s == SEQ_WAIT) begin
					found = 1'b1;
					st = s;
					cnt = len;
				end else begin
					s = succ(s, l, p);
				end
			end
		end
		lft = l;
	endfunction

	always_comb begin
		start = (per_cnt == '0);
		sh_n = sh;
		per_n = per_cnt - 1'b1;
		sync_n = (sync_cnt != '0) ? sync_cnt - 1'b1 : '0;
		state_n = state;
		seg_n = (state == SEQ_WAIT) ? seg_cnt : seg_cnt - 1'b1;
		left_n = left;
		if (start) begin
			// new period, take fresh params
			sh_n = params;
			per_n = params.period - 1'b1;
			sync_n = SYNC_W'(`SYNC_WIDTH);
			enter(SEQ_P1, params.cpmg, params, state_n, seg_n, left_n);
		end else if (state != SEQ_WAIT && seg_cnt == SEG_W'(1)) begin
			enter(succ(state, left, sh), left, sh, state_n, seg_n, left_n);
		end
	end

	always_ff @(posedge clk) begin
		if (resetn) begin
			// zero count starts a period right after reset
			per_cnt <= '0;
			sync_cnt <= '0;
			state <= SEQ_WAIT;
			seg_cnt <= '0;
			left <= '0;
			outs <= '0;
		end else begin
			per_cnt <= per_n;
			sync_cnt <= sync_n;
			state <= state_n;
			seg_cnt <= seg_n;
			left <= left_n;
			// outputs track the state being entered
			outs.sync <= (sync_n != '0);
			outs.pulse <= (state_n == SEQ_P1) || (state_n == SEQ_P2);
			outs.inhibit <= sh_n.block && (state_n != SEQ_WAIT);
		end
	end

	always_ff @(posedge clk) begin
		sh <= sh_n;
	end

endmodule

/* verilog/param_loader.sv */
`timescale 1ns/1ps
`include "pulse_gen_config.svh"

module param_loader import pulse_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic [7:0] rx_byte,
	input logic rx_valid,
	output pulse_params_t params
);

	cmd_op_t cur_op;
	// data bytes still expected, zero means no open frame
	logic [1:0] bytes_left;
	logic [23:0] data_sr;
	// last data byte seen, write field next cycle
	logic commit;

	// data byte count per opcode, zero for unknown bytes
	function automatic logic [1:0] op_bytes(input logic [7:0] b);
		case (b)
			OP_SET_PERIOD: return 2'd3;
			OP_SET_P1, OP_SET_DELAY, OP_SET_P2, OP_SET_BLOCK_OFF: return 2'd2;
			OP_SET_CPMG, OP_SET_BLOCK: return 2'd1;
			default: return 2'd0;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (resetn) begin
			cur_op <= OP_SET_PERIOD;
			bytes_left <= '0;
			commit <= 1'b0;
			params.period <= `PULSE_PERIOD_W'(`DEF_PERIOD);
			params.p1_width <= `PULSE_TIME_W'(`DEF_P1WIDTH);
			params.delay <= `PULSE_TIME_W'(`DEF_DELAY);
			params.p2_width <= `PULSE_TIME_W'(`DEF_P2WIDTH);
			params.block_off <= `PULSE_TIME_W'(`DEF_BLOCK_OFF);
			params.cpmg <= 8'(`DEF_CPMG);
			params.block <= 1'(`DEF_BLOCK);
		end else begin
			commit <= 1'b0;
			if (rx_valid) begin
				if (bytes_left == 2'd0) begin
					// opcode byte, unknown ones are dropped
					if (op_bytes(rx_byte) != 2'd0) begin
						cur_op <= cmd_op_t'(rx_byte);
						bytes_left <= op_bytes(rx_byte);
					end
				end else begin
					bytes_left <= bytes_left - 1'b1;
					if (bytes_left == 2'd1)
						commit <= 1'b1;
				end
			end
			// frame complete, update the named field only
			if (commit) begin
				case (cur_op)
					OP_SET_PERIOD: params.period <= data_sr;
					OP_SET_P1: params.p1_width <= data_sr[15:0];
					OP_SET_DELAY: params.delay <= data_sr[15:0];
					OP_SET_P2: params.p2_width <= data_sr[15:0];
					OP_SET_CPMG: params.cpmg <= data_sr[7:0];
					OP_SET_BLOCK: params.block <= data_sr[0];
					default: params.block_off <= data_sr[15:0];
				endcase
			end
		end
	end

	// msb first, low bytes hold the newest data
	always_ff @(posedge clk) begin
		if (rx_valid && bytes_left != 2'd0)
			data_sr <= {data_sr[15:0], rx_byte};
	end

endmodule

/* verilog/uart_rx.sv */
`timescale 1ns/1ps
`include "pulse_gen_config.svh"

module uart_rx (
	input logic clk,
	input logic resetn,
	input logic rx,
	output logic [7:0] rx_byte,
	output logic rx_valid
);

	localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
	// half a bit to reach mid start bit
	localparam logic [CNT_W-1:0] HALF = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] FULL = CNT_W'(`UART_CLKS_PER_BIT - 1);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t state;
	// two flop synchroniser
	logic rx_meta;
	logic rx_s;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0] bit_cnt;

	always_ff @(posedge clk) begin
		if (resetn) begin
			// line idles high
			rx_meta <= 1'b1;
			rx_s <= 1'b1;
			state <= RX_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_meta <= rx;
			rx_s <= rx_meta;
			rx_valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					// falling edge of start bit
					if (!rx_s) begin
						state <= RX_START;
						clk_cnt <= '0;
					end
				end
				RX_START: begin
					if (clk_cnt == HALF) begin
						clk_cnt <= '0;
						bit_cnt <= '0;
						// glitch, back to idle
						state <= rx_s ? RX_IDLE : RX_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (clk_cnt == FULL) begin
						clk_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= RX_STOP;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: begin
					// mid stop bit, framing error drops the byte
					if (clk_cnt == FULL) begin
						state <= RX_IDLE;
						rx_valid <= rx_s;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// lsb first, shift in from the top
	always_ff @(posedge clk) begin
		if (state == RX_DATA && clk_cnt == FULL)
			rx_byte <= {rx_s, rx_byte[7:1]};
	end

endmodule

/* verilog/pulse_pkg.sv */
`include "pulse_gen_config.svh"

package pulse_pkg;

	// one full parameter set
	typedef struct packed {
		logic [`PULSE_PERIOD_W-1:0] period;
		logic [`PULSE_TIME_W-1:0] p1_width;
		logic [`PULSE_TIME_W-1:0] delay;
		logic [`PULSE_TIME_W-1:0] p2_width;
		logic [`PULSE_TIME_W-1:0] block_off;
		// number of refocusing pulses
		logic [7:0] cpmg;
		// inhibit enable
		logic block;
	} pulse_params_t;

	typedef struct packed {
		logic sync;
		logic pulse;
		logic inhibit;
	} pulse_outs_t;

	// host command opcodes, data bytes follow msb first
	typedef enum logic [7:0] {
		OP_SET_PERIOD = 8'h01,
		OP_SET_P1 = 8'h02,
		OP_SET_DELAY = 8'h03,
		OP_SET_P2 = 8'h04,
		OP_SET_CPMG = 8'h05,
		OP_SET_BLOCK = 8'h06,
		OP_SET_BLOCK_OFF = 8'h07
	} cmd_op_t;

	typedef enum logic [2:0] {
		SEQ_P1,
		SEQ_GAP,
		SEQ_P2,
		SEQ_TAIL,
		SEQ_WAIT
	} seq_state_t;

endpackage

/* verilog/pulse_gen_config.svh */
`ifndef PULSE_GEN_CONFIG_SVH
`define PULSE_GEN_CONFIG_SVH

// counter widths
`define PULSE_PERIOD_W 24
`define PULSE_TIME_W 16

// serial bit time in clk cycles, kept short for simulation
`define UART_CLKS_PER_BIT 8

// sync strobe length in clk cycles
`define SYNC_WIDTH 4

// power-up sequence, a Hahn echo with blanking on
`define DEF_PERIOD 4096
`define DEF_P1WIDTH 30
`define DEF_DELAY 200
`define DEF_P2WIDTH 60
// one refocusing pulse
`define DEF_CPMG 1
`define DEF_BLOCK 1
// tail of receiver blanking after the last pulse
`define DEF_BLOCK_OFF 100

`endif
